/* Makefile */
VERILATOR = verilator
VFLAGS    = --binary -j 0 -Wno-fatal
TOP       = id_stage_tb
FILELIST  = tb.f
OBJ_DIR   = obj_dir
PASS_MSG  = Everything OK

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: compile
	./$(OBJ_DIR)/V$(TOP) | tee /dev/stderr | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

/* source/branch_unit.sv */
`timescale 1ns/10ps
`default_nettype none

module branch_unit (
    input  var id_pkg::br_kind_e       br_kind,
    input  wire [id_pkg::xlen-1:0]     rs1_value,
    input  wire [id_pkg::xlen-1:0]     rs2_value,
    input  wire [id_pkg::xlen-1:0]     pc,
    input  wire [id_pkg::xlen-1:0]     br_offs,
    output logic                       cond_true,
    output logic [id_pkg::xlen-1:0]    target
);

    logic eq;
    logic lt;
    logic ltu;

    assign eq  = rs1_value == rs2_value;
    assign lt  = $signed(rs1_value) < $signed(rs2_value);
    assign ltu = rs1_value < rs2_value;

    always_comb begin
        case (br_kind)
            id_pkg::BR_EQ:        cond_true = eq;
            id_pkg::BR_NE:        cond_true = !eq;
            id_pkg::BR_LT:        cond_true = lt;
            id_pkg::BR_GE:        cond_true = !lt;
            id_pkg::BR_LTU:       cond_true = ltu;
            id_pkg::BR_GEU:       cond_true = !ltu;
            id_pkg::BR_ALWAYS_PC,
            id_pkg::BR_JIRL:      cond_true = 1'b1;
            default:              cond_true = 1'b0;
        endcase
    end

    // jirl is register relative, everything else pc relative
    assign target = ((br_kind == id_pkg::BR_JIRL) ? rs1_value : pc) + br_offs;

endmodule

`default_nettype wire

/* source/id_pkg.sv */
`default_nettype none

package id_pkg;

    localparam int xlen       = 32;  // data and address width
    localparam int inst_w     = 32;
    localparam int reg_addr_w = 5;
    localparam int num_regs   = 32;

    // bl links the return address here
    localparam logic [reg_addr_w-1:0] link_reg = 5'd1;

    // alu operation handed to EX
    typedef enum logic [3:0] {
        ALU_ADD,   // also address calc, jirl, bl, pcaddu12i
        ALU_SUB,
        ALU_SLT,
        ALU_SLTU,
        ALU_AND,
        ALU_NOR,
        ALU_OR,
        ALU_XOR,
        ALU_SLL,
        ALU_SRL,
        ALU_SRA,
        ALU_LUI    // src2 passes through
    } alu_op_e;

    // memory access width
    typedef enum logic [1:0] {
        MEM_BYTE,
        MEM_HALF,
        MEM_WORD
    } mem_size_e;

    // branch class, picks the condition and the target base
    typedef enum logic [3:0] {
        BR_NONE,
        BR_EQ,
        BR_NE,
        BR_LT,
        BR_GE,
        BR_LTU,
        BR_GEU,
        BR_ALWAYS_PC,  // b and bl
        BR_JIRL        // target from rj
    } br_kind_e;

endpackage

`default_nettype wire

/* source/id_stage.sv */
`timescale 1ns/10ps
`default_nettype none

module id_stage (
    input  wire                           clk,
    input  wire                           resetn,
    // fetch side
    input  wire                           if_to_id_valid,
    input  wire [id_pkg::inst_w-1:0]      if_inst,
    input  wire [id_pkg::xlen-1:0]        if_pc,
    output logic                          id_allowin,
    output logic                          br_taken,
    output logic [id_pkg::xlen-1:0]       br_target,
    // EX side
    input  wire                           ex_allowin,
    output logic                          id_to_ex_valid,
    output id_pkg::alu_op_e               ex_alu_op,
    output logic [id_pkg::xlen-1:0]       ex_src1,
    output logic [id_pkg::xlen-1:0]       ex_src2,
    output logic [id_pkg::xlen-1:0]       ex_store_data,
    output logic                          ex_mem_we,
    output logic                          ex_res_from_mem,
    output id_pkg::mem_size_e             ex_mem_size,
    output logic                          ex_mem_unsigned,
    output logic                          ex_rf_we,
    output logic [id_pkg::reg_addr_w-1:0] ex_rf_waddr,
    output logic [id_pkg::xlen-1:0]       ex_pc,
    // forwarding and writeback
    input  wire                           ex_fwd_we,
    input  wire [id_pkg::reg_addr_w-1:0]  ex_fwd_waddr,
    input  wire [id_pkg::xlen-1:0]        ex_fwd_wdata,
    input  wire                           ex_fwd_is_load,
    input  wire                           mem_fwd_we,
    input  wire [id_pkg::reg_addr_w-1:0]  mem_fwd_waddr,
    input  wire [id_pkg::xlen-1:0]        mem_fwd_wdata,
    input  wire                           wb_rf_we,
    input  wire [id_pkg::reg_addr_w-1:0]  wb_rf_waddr,
    input  wire [id_pkg::xlen-1:0]        wb_rf_wdata
);

    logic                          id_valid;
    logic [id_pkg::inst_w-1:0]     id_inst;
    logic [id_pkg::xlen-1:0]       id_pc;
    logic                          id_ready_go;

    logic                          src1_is_pc, src2_is_imm;
    logic [id_pkg::xlen-1:0]       imm, br_offs;
    logic [id_pkg::reg_addr_w-1:0] rs1, rs2;
    logic                          need_rs1, need_rs2;
    logic                          rf_we_raw, mem_we_raw, is_load;
    id_pkg::br_kind_e              br_kind;
    logic [id_pkg::xlen-1:0]       rf_rdata1, rf_rdata2;
    logic [id_pkg::xlen-1:0]       rs1_value, rs2_value;
    logic                          stall, cond_true;

    assign id_ready_go    = !stall;
    assign id_allowin     = !id_valid || (id_ready_go && ex_allowin);
    assign id_to_ex_valid = id_valid && id_ready_go;
    assign br_taken       = id_to_ex_valid && ex_allowin && cond_true;

    always_ff @(posedge clk) begin
        if (!resetn)
            id_valid <= 1'b0;
        else if (br_taken)
            id_valid <= 1'b0;  // drop the wrong-path fetch
        else if (id_allowin)
            id_valid <= if_to_id_valid;
    end

    always_ff @(posedge clk) begin
        if (if_to_id_valid && id_allowin) begin
            id_inst <= if_inst;
            id_pc   <= if_pc;
        end
    end

    inst_decoder inst_decoder_i (
        .inst(id_inst), .alu_op(ex_alu_op), .src1_is_pc(src1_is_pc),
        .src2_is_imm(src2_is_imm), .imm(imm), .rs1(rs1), .rs2(rs2),
        .need_rs1(need_rs1), .need_rs2(need_rs2), .rf_we_raw(rf_we_raw),
        .rd_addr(ex_rf_waddr), .mem_we_raw(mem_we_raw), .is_load(is_load),
        .mem_size(ex_mem_size), .mem_unsigned(ex_mem_unsigned),
        .br_kind(br_kind), .br_offs(br_offs)
    );

    regfile regfile_i (
        .clk(clk), .raddr1(rs1), .raddr2(rs2),
        .we(wb_rf_we), .waddr(wb_rf_waddr), .wdata(wb_rf_wdata),
        .rdata1(rf_rdata1), .rdata2(rf_rdata2)
    );

    operand_forward operand_forward_i (
        .rs1(rs1), .rs2(rs2), .need_rs1(need_rs1), .need_rs2(need_rs2),
        .rf_rdata1(rf_rdata1), .rf_rdata2(rf_rdata2),
        .ex_fwd_we(ex_fwd_we), .ex_fwd_waddr(ex_fwd_waddr),
        .ex_fwd_wdata(ex_fwd_wdata), .ex_fwd_is_load(ex_fwd_is_load),
        .mem_fwd_we(mem_fwd_we), .mem_fwd_waddr(mem_fwd_waddr),
        .mem_fwd_wdata(mem_fwd_wdata), .wb_rf_we(wb_rf_we),
        .wb_rf_waddr(wb_rf_waddr), .wb_rf_wdata(wb_rf_wdata),
        .rs1_value(rs1_value), .rs2_value(rs2_value), .stall(stall)
    );

    branch_unit branch_unit_i (
        .br_kind(br_kind), .rs1_value(rs1_value), .rs2_value(rs2_value),
        .pc(id_pc), .br_offs(br_offs), .cond_true(cond_true), .target(br_target)
    );

    assign ex_src1       = src1_is_pc ? id_pc : rs1_value;
    assign ex_src2       = src2_is_imm ? imm : rs2_value;
    assign ex_store_data = rs2_value;  // rd for stores
    assign ex_pc         = id_pc;

    // side effects only for a live instruction
    assign ex_rf_we        = id_valid && rf_we_raw;
    assign ex_mem_we       = id_valid && mem_we_raw;
    assign ex_res_from_mem = id_valid && is_load;

endmodule

`default_nettype wire

/* source/inst_decoder.sv */
`timescale 1ns/10ps
`default_nettype none

module inst_decoder (
    input  wire [id_pkg::inst_w-1:0]     inst,
    output id_pkg::alu_op_e              alu_op,
    output logic                         src1_is_pc,
    output logic                         src2_is_imm,
    output logic [id_pkg::xlen-1:0]      imm,
    output logic [id_pkg::reg_addr_w-1:0] rs1,
    output logic [id_pkg::reg_addr_w-1:0] rs2,
    output logic                         need_rs1,
    output logic                         need_rs2,
    output logic                         rf_we_raw,
    output logic [id_pkg::reg_addr_w-1:0] rd_addr,
    output logic                         mem_we_raw,
    output logic                         is_load,
    output id_pkg::mem_size_e            mem_size,
    output logic                         mem_unsigned,
    output id_pkg::br_kind_e             br_kind,
    output logic [id_pkg::xlen-1:0]      br_offs
);

    wire [5:0]  op_31_26 = inst[31:26];
    wire [3:0]  op_25_22 = inst[25:22];
    wire [1:0]  op_21_20 = inst[21:20];
    wire [4:0]  op_19_15 = inst[19:15];
    wire [4:0]  rd       = inst[4:0];
    wire [4:0]  rj       = inst[9:5];
    wire [4:0]  rk       = inst[14:10];
    wire [11:0] i12      = inst[21:10];
    wire [19:0] i20      = inst[24:5];
    wire [15:0] i16      = inst[25:10];
    wire [25:0] i26      = {inst[9:0], inst[25:10]};  // offs[15:0] sits in the high field

    // opcode groups
    wire grp_3r  = op_31_26 == 6'h00 && op_25_22 == 4'h0 && op_21_20 == 2'h1;
    wire grp_sh  = op_31_26 == 6'h00 && op_25_22 == 4'h1 && op_21_20 == 2'h0;
    wire grp_2ri = op_31_26 == 6'h00;
    wire grp_mem = op_31_26 == 6'h0a;

    wire inst_add_w  = grp_3r && op_19_15 == 5'h00;
    wire inst_sub_w  = grp_3r && op_19_15 == 5'h02;
    wire inst_slt    = grp_3r && op_19_15 == 5'h04;
    wire inst_sltu   = grp_3r && op_19_15 == 5'h05;
    wire inst_nor    = grp_3r && op_19_15 == 5'h08;
    wire inst_and    = grp_3r && op_19_15 == 5'h09;
    wire inst_or     = grp_3r && op_19_15 == 5'h0a;
    wire inst_xor    = grp_3r && op_19_15 == 5'h0b;
    wire inst_sll_w  = grp_3r && op_19_15 == 5'h0e;
    wire inst_srl_w  = grp_3r && op_19_15 == 5'h0f;
    wire inst_sra_w  = grp_3r && op_19_15 == 5'h10;
    wire inst_slli_w = grp_sh && op_19_15 == 5'h01;
    wire inst_srli_w = grp_sh && op_19_15 == 5'h09;
    wire inst_srai_w = grp_sh && op_19_15 == 5'h11;
    wire inst_slti   = grp_2ri && op_25_22 == 4'h8;
    wire inst_sltui  = grp_2ri && op_25_22 == 4'h9;
    wire inst_addi_w = grp_2ri && op_25_22 == 4'ha;
    wire inst_andi   = grp_2ri && op_25_22 == 4'hd;
    wire inst_ori    = grp_2ri && op_25_22 == 4'he;
    wire inst_xori   = grp_2ri && op_25_22 == 4'hf;
    wire inst_lu12i  = op_31_26 == 6'h05 && !inst[25];
    wire inst_pcadd  = op_31_26 == 6'h07 && !inst[25];  // pcaddu12i
    wire inst_jirl   = op_31_26 == 6'h13;
    wire inst_b      = op_31_26 == 6'h14;
    wire inst_bl     = op_31_26 == 6'h15;
    wire inst_cbr    = op_31_26 >= 6'h16 && op_31_26 <= 6'h1b;  // beq .. bgeu

    // loads 0/1/2/8/9, stores 4/5/6
    wire inst_load  = grp_mem && (op_25_22 <= 4'h2 || op_25_22 == 4'h8 || op_25_22 == 4'h9);
    wire inst_store = grp_mem && op_25_22 >= 4'h4 && op_25_22 <= 4'h6;

    wire alu_r = inst_add_w | inst_sub_w | inst_slt | inst_sltu | inst_nor | inst_and
               | inst_or | inst_xor | inst_sll_w | inst_srl_w | inst_sra_w;
    wire alu_i = inst_slli_w | inst_srli_w | inst_srai_w | inst_slti | inst_sltui
               | inst_addi_w | inst_andi | inst_ori | inst_xori;

    wire need_ui12 = inst_andi | inst_ori | inst_xori;
    wire need_si20 = inst_lu12i | inst_pcadd;
    wire src2_is_4 = inst_jirl | inst_bl;  // link address pc + 4

    assign rs1 = rj;
    assign rs2 = (inst_cbr || inst_store) ? rd : rk;

    assign need_rs1    = alu_r | alu_i | inst_load | inst_store | inst_cbr | inst_jirl;
    assign need_rs2    = alu_r | inst_store | inst_cbr;
    assign src1_is_pc  = inst_jirl | inst_bl | inst_pcadd;
    assign src2_is_imm = alu_i | inst_load | inst_store | need_si20 | src2_is_4;

    assign rf_we_raw  = alu_r | alu_i | inst_load | need_si20 | inst_jirl | inst_bl;
    assign rd_addr    = inst_bl ? id_pkg::link_reg : rd;
    assign mem_we_raw = inst_store;
    assign is_load    = inst_load;

    assign imm = src2_is_4 ? 32'd4               :
                 need_si20 ? {i20, 12'b0}        :
                 need_ui12 ? {20'b0, i12}        :
                             {{20{i12[11]}}, i12};  // si12, and ui5 in the low bits

    assign br_offs = (inst_b || inst_bl) ? {{4{i26[25]}}, i26, 2'b0}
                                         : {{14{i16[15]}}, i16, 2'b0};

    assign mem_unsigned = inst_load && op_25_22[3];

    always_comb begin
        mem_size = id_pkg::MEM_WORD;
        if (inst_load || inst_store) begin
            if (op_25_22[1:0] == 2'd0)
                mem_size = id_pkg::MEM_BYTE;
            else if (op_25_22[1:0] == 2'd1)
                mem_size = id_pkg::MEM_HALF;
        end
    end

    always_comb begin
        alu_op = id_pkg::ALU_ADD;  // add, addi, mem, links, unknown
        if (inst_sub_w)                      alu_op = id_pkg::ALU_SUB;
        else if (inst_slt || inst_slti)      alu_op = id_pkg::ALU_SLT;
        else if (inst_sltu || inst_sltui)    alu_op = id_pkg::ALU_SLTU;
        else if (inst_and || inst_andi)      alu_op = id_pkg::ALU_AND;
        else if (inst_nor)                   alu_op = id_pkg::ALU_NOR;
        else if (inst_or || inst_ori)        alu_op = id_pkg::ALU_OR;
        else if (inst_xor || inst_xori)      alu_op = id_pkg::ALU_XOR;
        else if (inst_sll_w || inst_slli_w)  alu_op = id_pkg::ALU_SLL;
        else if (inst_srl_w || inst_srli_w)  alu_op = id_pkg::ALU_SRL;
        else if (inst_sra_w || inst_srai_w)  alu_op = id_pkg::ALU_SRA;
        else if (inst_lu12i)                 alu_op = id_pkg::ALU_LUI;
    end

    always_comb begin
        br_kind = id_pkg::BR_NONE;
        if (inst_b || inst_bl)
            br_kind = id_pkg::BR_ALWAYS_PC;
        else if (inst_jirl)
            br_kind = id_pkg::BR_JIRL;
        else if (inst_cbr) begin
            case (op_31_26[2:0])  // 16..1b
                3'h6:    br_kind = id_pkg::BR_EQ;
                3'h7:    br_kind = id_pkg::BR_NE;
                3'h0:    br_kind = id_pkg::BR_LT;
                3'h1:    br_kind = id_pkg::BR_GE;
                3'h2:    br_kind = id_pkg::BR_LTU;
                default: br_kind = id_pkg::BR_GEU;
            endcase
        end
    end

endmodule

`default_nettype wire

/* source/operand_forward.sv */
`timescale 1ns/10ps
`default_nettype none

module operand_forward (
    input  wire [id_pkg::reg_addr_w-1:0]  rs1,
    input  wire [id_pkg::reg_addr_w-1:0]  rs2,
    input  wire                           need_rs1,
    input  wire                           need_rs2,
    input  wire [id_pkg::xlen-1:0]        rf_rdata1,
    input  wire [id_pkg::xlen-1:0]        rf_rdata2,
    input  wire                           ex_fwd_we,
    input  wire [id_pkg::reg_addr_w-1:0]  ex_fwd_waddr,
    input  wire [id_pkg::xlen-1:0]        ex_fwd_wdata,
    input  wire                           ex_fwd_is_load,
    input  wire                           mem_fwd_we,
    input  wire [id_pkg::reg_addr_w-1:0]  mem_fwd_waddr,
    input  wire [id_pkg::xlen-1:0]        mem_fwd_wdata,
    input  wire                           wb_rf_we,
    input  wire [id_pkg::reg_addr_w-1:0]  wb_rf_waddr,
    input  wire [id_pkg::xlen-1:0]        wb_rf_wdata,
    output logic [id_pkg::xlen-1:0]       rs1_value,
    output logic [id_pkg::xlen-1:0]       rs2_value,
    output logic                          stall
);

    // needed nonzero source matched by a writing stage
    function automatic logic hit(input logic [id_pkg::reg_addr_w-1:0] src,
                                 input logic                          need,
                                 input logic                          we,
                                 input logic [id_pkg::reg_addr_w-1:0] waddr);
        return need && src != '0 && we && src == waddr;
    endfunction

    logic r1_ex, r1_mem, r1_wb;
    logic r2_ex, r2_mem, r2_wb;

    assign r1_ex  = hit(rs1, need_rs1, ex_fwd_we, ex_fwd_waddr);
    assign r1_mem = hit(rs1, need_rs1, mem_fwd_we, mem_fwd_waddr);
    assign r1_wb  = hit(rs1, need_rs1, wb_rf_we, wb_rf_waddr);
    assign r2_ex  = hit(rs2, need_rs2, ex_fwd_we, ex_fwd_waddr);
    assign r2_mem = hit(rs2, need_rs2, mem_fwd_we, mem_fwd_waddr);
    assign r2_wb  = hit(rs2, need_rs2, wb_rf_we, wb_rf_waddr);

    // youngest producer wins
    assign rs1_value = r1_ex  ? ex_fwd_wdata  :
                       r1_mem ? mem_fwd_wdata :
                       r1_wb  ? wb_rf_wdata   : rf_rdata1;
    assign rs2_value = r2_ex  ? ex_fwd_wdata  :
                       r2_mem ? mem_fwd_wdata :
                       r2_wb  ? wb_rf_wdata   : rf_rdata2;

    // load data not back until MEM
    assign stall = ex_fwd_is_load && (r1_ex || r2_ex);

endmodule

`default_nettype wire

/* source/regfile.sv */
`timescale 1ns/10ps
`default_nettype none

module regfile (
    input  wire                           clk,
    input  wire [id_pkg::reg_addr_w-1:0]  raddr1,
    input  wire [id_pkg::reg_addr_w-1:0]  raddr2,
    input  wire                           we,
    input  wire [id_pkg::reg_addr_w-1:0]  waddr,
    input  wire [id_pkg::xlen-1:0]        wdata,
    output logic [id_pkg::xlen-1:0]       rdata1,
    output logic [id_pkg::xlen-1:0]       rdata2
);

    logic [id_pkg::xlen-1:0] rf [id_pkg::num_regs];

    always_ff @(posedge clk) begin
        if (we && waddr != '0)  // r0 stays zero
            rf[waddr] <= wdata;
    end

    // async read, same-cycle writes come through forwarding
    assign rdata1 = (raddr1 == '0) ? '0 : rf[raddr1];
    assign rdata2 = (raddr2 == '0) ? '0 : rf[raddr2];

endmodule

`default_nettype wire

/* tb.f */
source/id_pkg.sv
source/inst_decoder.sv
source/regfile.sv
source/operand_forward.sv
source/branch_unit.sv
source/id_stage.sv
test/tb_clock.sv
test/id_stage_tb.sv

/* test/id_stage_tb.sv */
`timescale 1ns/10ps
`default_nettype none

module id_stage_tb;

    typedef struct {
        string                 name;
        logic [31:0]           inst, pc;
        logic                  exw, exl, mw, wbw, allow;
        logic [4:0]            exa, ma, wba;
        logic [31:0]           exd, md, wbd;
        id_pkg::alu_op_e       alu;
        logic [1:0]            s1, s2;  // 0 register, 1 pc or imm, 2 don't care
        logic [31:0]           imm, offs;
        logic                  rfwe, memwe, load, uns;
        logic [4:0]            waddr, rs1, rs2;
        id_pkg::mem_size_e     size;
        logic [3:0]            cond;    // 1 eq .. 6 geu, 7 always, 8 jirl
    } row_t;

    localparam int preload_writes = 9;

    wire clk, resetn;
    logic if_to_id_valid, ex_allowin, ex_fwd_we, ex_fwd_is_load, mem_fwd_we, wb_rf_we;
    logic [31:0] if_inst, if_pc, ex_fwd_wdata, mem_fwd_wdata, wb_rf_wdata;
    logic [4:0] ex_fwd_waddr, mem_fwd_waddr, wb_rf_waddr;
    logic id_allowin, br_taken, id_to_ex_valid, ex_mem_we, ex_res_from_mem;
    logic ex_mem_unsigned, ex_rf_we;
    logic [31:0] br_target, ex_src1, ex_src2, ex_store_data, ex_pc;
    logic [4:0] ex_rf_waddr;
    id_pkg::alu_op_e ex_alu_op;
    id_pkg::mem_size_e ex_mem_size;

    row_t rows[$];
    logic [31:0] model [32];
    int row_errs, passed, failed;
    bit table_ready;

    // 3r opcodes in the order of their alu ops
    logic [31:0] code_3r [11] = '{32'h0010_0000, 32'h0011_0000, 32'h0012_0000,
        32'h0012_8000, 32'h0014_8000, 32'h0014_0000, 32'h0015_0000, 32'h0015_8000,
        32'h0017_0000, 32'h0017_8000, 32'h0018_0000};
    id_pkg::alu_op_e alu_3r [11] = '{id_pkg::ALU_ADD, id_pkg::ALU_SUB, id_pkg::ALU_SLT,
        id_pkg::ALU_SLTU, id_pkg::ALU_AND, id_pkg::ALU_NOR, id_pkg::ALU_OR,
        id_pkg::ALU_XOR, id_pkg::ALU_SLL, id_pkg::ALU_SRL, id_pkg::ALU_SRA};

    tb_clock tb_clock_i (.clk(clk), .resetn(resetn));

    id_stage id_stage_i (.*);

    function automatic logic [31:0] enc(logic [31:0] op, logic [15:0] imm,
                                        logic [4:0] rj, logic [4:0] rd);
        return op | (32'(imm) << 10) | (32'(rj) << 5) | 32'(rd);
    endfunction

    function automatic row_t mk(string name, logic [31:0] inst, id_pkg::alu_op_e alu);
        row_t r;
        r.name = name;
        r.inst = inst;
        r.pc = 32'h1c00_0000 + 32'(rows.size()) * 4;
        r.exw = 0;
        r.exl = 0;
        r.mw = 0;
        r.wbw = 0;
        r.allow = 1;
        r.exa = 0;
        r.ma = 0;
        r.wba = 0;
        r.exd = 0;
        r.md = 0;
        r.wbd = 0;
        r.alu = alu;
        r.s1 = 0;
        r.s2 = 0;
        r.imm = 0;
        r.offs = 0;
        r.cond = 0;
        r.rfwe = 1;
        r.memwe = 0;
        r.load = 0;
        r.uns = 0;
        r.waddr = inst[4:0];
        r.rs1 = inst[9:5];
        r.rs2 = inst[14:10];
        r.size = id_pkg::MEM_WORD;
        return r;
    endfunction

    function automatic void push_imm(string name, logic [31:0] inst,
                                     id_pkg::alu_op_e alu, logic [31:0] imm);
        row_t r;
        r = mk(name, inst, alu);
        r.s2 = 1;
        r.imm = imm;
        rows.push_back(r);
    endfunction

    function automatic void push_mem(string name, logic [31:0] op, logic load,
                                     id_pkg::mem_size_e size, logic uns);
        row_t r;
        r = mk(name, enc(op, 16'h0ffc, 4, 3), id_pkg::ALU_ADD);
        r.s2 = 1;
        r.imm = 32'hffff_fffc;  // si12 sign extended
        r.size = size;
        r.load = load;
        r.uns = uns;
        r.rfwe = load;
        r.memwe = !load;
        r.rs2 = 3;  // store data comes from rd
        rows.push_back(r);
    endfunction

    // en holds the ex, mem and wb write enables from the top bit down
    function automatic void push_fwd(string name, logic [31:0] inst, logic [2:0] en,
                                     logic [4:0] exa, logic [31:0] exd,
                                     logic [4:0] ma, logic [31:0] md,
                                     logic [4:0] wba, logic [31:0] wbd);
        row_t r;
        r = mk(name, inst, id_pkg::ALU_ADD);
        r.exw = en[2];
        r.exa = exa;
        r.exd = exd;
        r.mw = en[1];
        r.ma = ma;
        r.md = md;
        r.wbw = en[0];
        r.wba = wba;
        r.wbd = wbd;
        rows.push_back(r);
    endfunction

    // offs is the byte offset, encoded as si16 words
    function automatic void push_br(string name, logic [31:0] op, logic [4:0] rj,
                                    logic [4:0] rd, logic [3:0] cond, logic [31:0] offs);
        row_t r;
        r = mk(name, enc(op, offs[17:2], rj, rd), id_pkg::ALU_ADD);
        r.rs2 = rd;
        r.rfwe = 0;
        r.cond = cond;
        r.offs = offs;
        rows.push_back(r);
    endfunction

    function automatic void build_table();
        row_t r;
        for (int i = 0; i < 11; i++)
            rows.push_back(mk($sformatf("3r op %0d", i),
                enc(code_3r[i], 16'(1 + (i + 2) % 6), 5'(1 + i % 6), 5'(9 + i)), alu_3r[i]));
        rows.push_back(mk("r0 reads zero", enc(code_3r[0], 0, 0, 10), id_pkg::ALU_ADD));
        push_imm("addi.w", enc(32'h0280_0000, 16'h0fff, 1, 11), id_pkg::ALU_ADD, 32'hffff_ffff);
        push_imm("slti", enc(32'h0200_0000, 16'h0800, 2, 12), id_pkg::ALU_SLT, 32'hffff_f800);
        push_imm("andi", enc(32'h0340_0000, 16'h08f0, 3, 13), id_pkg::ALU_AND, 32'h0000_08f0);
        push_imm("ori", enc(32'h0380_0000, 16'h0abc, 4, 14), id_pkg::ALU_OR, 32'h0000_0abc);
        push_imm("xori", enc(32'h03c0_0000, 16'h0fff, 5, 15), id_pkg::ALU_XOR, 32'h0000_0fff);
        push_imm("slli.w", enc(32'h0040_8000, 16'h0005, 6, 16), id_pkg::ALU_SLL, 32'h0000_0025);
        r = mk("lu12i.w", 32'h1400_0000 | (32'h8_1234 << 5) | 32'd11, id_pkg::ALU_LUI);
        r.s1 = 2;
        r.s2 = 1;
        r.imm = 32'h8123_4000;
        rows.push_back(r);
        r = mk("pcaddu12i", 32'h1c00_0000 | (32'h12 << 5) | 32'd12, id_pkg::ALU_ADD);
        r.s1 = 1;
        r.s2 = 1;
        r.imm = 32'h0001_2000;
        rows.push_back(r);
        push_mem("ld.b", 32'h2800_0000, 1, id_pkg::MEM_BYTE, 0);
        push_mem("ld.h", 32'h2840_0000, 1, id_pkg::MEM_HALF, 0);
        push_mem("ld.w", 32'h2880_0000, 1, id_pkg::MEM_WORD, 0);
        push_mem("ld.bu", 32'h2a00_0000, 1, id_pkg::MEM_BYTE, 1);
        push_mem("ld.hu", 32'h2a40_0000, 1, id_pkg::MEM_HALF, 1);
        push_mem("st.b", 32'h2900_0000, 0, id_pkg::MEM_BYTE, 0);
        push_mem("st.h", 32'h2940_0000, 0, id_pkg::MEM_HALF, 0);
        push_mem("st.w", 32'h2980_0000, 0, id_pkg::MEM_WORD, 0);
        push_fwd("ex beats mem", enc(code_3r[0], 6, 5, 17), 3'b111,
                 5, 32'hdead_0001, 5, 32'hbeef_0002, 5, 32'hcafe_0003);
        push_fwd("mem forward", enc(code_3r[0], 6, 5, 18), 3'b011,
                 0, 0, 6, 32'h1234_5678, 6, 32'h8765_4321);
        push_fwd("wb forward", enc(code_3r[0], 6, 5, 23), 3'b001,
                 0, 0, 0, 0, 6, 32'h0f0f_a5a5);
        push_fwd("r0 not forwarded", enc(code_3r[0], 6, 0, 19), 3'b111,
                 0, 32'hffff_ffff, 0, 32'h55, 0, 32'haaaa);
        r = mk("load-use stall", enc(code_3r[0], 6, 5, 20), id_pkg::ALU_ADD);
        r.exw = 1;
        r.exa = 6;
        r.exd = 32'h0bad_cafe;
        r.exl = 1;
        rows.push_back(r);
        r = mk("back-pressure", enc(code_3r[7], 2, 1, 21), id_pkg::ALU_XOR);
        r.allow = 0;
        rows.push_back(r);
        push_br("beq taken", 32'h5800_0000, 3, 3, 1, 32'h0000_0040);
        push_br("bne not taken", 32'h5c00_0000, 3, 3, 2, 32'h0000_0040);
        push_br("blt", 32'h6000_0000, 7, 8, 3, 32'hffff_ffc0);
        push_br("bge", 32'h6400_0000, 7, 8, 4, 32'h0000_0080);
        push_br("bltu", 32'h6800_0000, 7, 8, 5, 32'h0000_0080);
        push_br("bgeu", 32'h6c00_0000, 7, 8, 6, 32'hffff_ffc0);
        r = mk("b", 32'h5000_0000 | (32'h20 << 10), id_pkg::ALU_ADD);
        r.s1 = 2;
        r.s2 = 2;
        r.rfwe = 0;
        r.cond = 7;
        r.offs = 32'h80;
        rows.push_back(r);
        r = mk("bl", 32'h5400_0000 | (32'h40 << 10), id_pkg::ALU_ADD);
        r.s1 = 1;
        r.s2 = 1;
        r.imm = 4;
        r.waddr = 1;
        r.cond = 7;
        r.offs = 32'h100;
        rows.push_back(r);
        r = mk("jirl", enc(32'h4c00_0000, 16'h0004, 2, 22), id_pkg::ALU_ADD);
        r.s1 = 1;
        r.s2 = 1;
        r.imm = 4;
        r.cond = 8;
        r.offs = 32'h10;
        rows.push_back(r);
    endfunction

    // operand value after forwarding, r0 always zero
    function automatic logic [31:0] opnd(row_t r, logic [4:0] idx);
        if (idx == 0)
            return 0;
        if (r.exw && r.exa == idx)
            return r.exd;
        if (r.mw && r.ma == idx)
            return r.md;
        if (r.wbw && r.wba == idx)
            return r.wbd;
        return model[idx];
    endfunction

    task automatic check(input string what, input logic [31:0] got, input logic [31:0] exp);
        assert (got === exp) else begin
            $display("[ERROR] %0t: %s is %h, expected %h", $time, what, got, exp);
            row_errs++;
        end
    endtask

    task automatic report_test(input string name);
        $display("test %s: %s", name, row_errs == 0 ? "pass" : "FAIL");
        if (row_errs == 0)
            passed++;
        else
            failed++;
    endtask

    task automatic preload();
        logic [31:0] v;
        for (int i = 0; i < preload_writes; i++) begin
            v = (i == 7) ? 32'h8000_0005 : (i == 8) ? 32'd3 : $urandom;  // r7 negative
            @(negedge clk);
            wb_rf_we = 1;
            wb_rf_waddr = 5'(i);
            wb_rf_wdata = v;
            model[i] = (i == 0) ? 32'd0 : v;
        end
        @(negedge clk);
        wb_rf_we = 0;
    endtask

    task automatic run_row(input row_t r);
        logic [31:0] a, b;
        logic taken;
        a = opnd(r, r.rs1);
        b = opnd(r, r.rs2);
        case (r.cond)
            1: taken = a == b;
            2: taken = a != b;
            3: taken = $signed(a) < $signed(b);
            4: taken = $signed(a) >= $signed(b);
            5: taken = a < b;
            6: taken = a >= b;
            7, 8: taken = 1;
            default: taken = 0;
        endcase
        @(negedge clk);
        if_to_id_valid = 1;
        if_inst = r.inst;
        if_pc = r.pc;
        ex_fwd_we = r.exw;
        ex_fwd_waddr = r.exa;
        ex_fwd_wdata = r.exd;
        ex_fwd_is_load = r.exl;
        mem_fwd_we = r.mw;
        mem_fwd_waddr = r.ma;
        mem_fwd_wdata = r.md;
        ex_allowin = r.allow;
        #1;
        while (!id_allowin) begin
            @(negedge clk);
            #1;
        end
        @(posedge clk);  // accepted here
        @(negedge clk);
        if (r.exl || !r.allow) begin
            if_to_id_valid = 1;  // next offer has to wait
            if_inst = enc(code_3r[0], 2, 2, 2);
            if_pc = r.pc + 8;
            repeat (3) begin
                #1;
                check("id_to_ex_valid held", 32'(id_to_ex_valid), 32'(!r.exl));
                check("id_allowin held", 32'(id_allowin), 0);
                check("ex_pc held", ex_pc, r.pc);
                @(negedge clk);
            end
            ex_fwd_is_load = 0;
            ex_allowin = 1;
        end
        if_to_id_valid = taken;  // wrong-path offer, must be dropped
        if_inst = enc(code_3r[0], 1, 1, 1);
        if_pc = r.pc + 4;
        wb_rf_we = r.wbw;  // array still holds the old value this cycle
        wb_rf_waddr = r.wba;
        wb_rf_wdata = r.wbd;
        #1;
        check("id_to_ex_valid", 32'(id_to_ex_valid), 1);
        check("ex_alu_op", 32'(ex_alu_op), 32'(r.alu));
        check("ex_pc", ex_pc, r.pc);
        if (r.s1 != 2)
            check("ex_src1", ex_src1, (r.s1 == 1) ? r.pc : a);
        if (r.s2 != 2)
            check("ex_src2", ex_src2, (r.s2 == 1) ? r.imm : b);
        check("ex_rf_we", 32'(ex_rf_we), 32'(r.rfwe));
        if (r.rfwe)
            check("ex_rf_waddr", 32'(ex_rf_waddr), 32'(r.waddr));
        check("ex_mem_we", 32'(ex_mem_we), 32'(r.memwe));
        check("ex_res_from_mem", 32'(ex_res_from_mem), 32'(r.load));
        if (r.load || r.memwe) begin
            check("ex_mem_size", 32'(ex_mem_size), 32'(r.size));
            check("ex_mem_unsigned", 32'(ex_mem_unsigned), 32'(r.uns));
        end
        if (r.memwe)
            check("ex_store_data", ex_store_data, b);
        check("br_taken", 32'(br_taken), 32'(taken));
        if (taken)
            check("br_target", br_target, (r.cond == 8) ? a + r.offs : r.pc + r.offs);
        @(posedge clk);
        @(negedge clk);
        if_to_id_valid = 0;
        ex_fwd_we = 0;
        ex_fwd_is_load = 0;
        mem_fwd_we = 0;
        wb_rf_we = 0;
        if (r.wbw && r.wba != 0)
            model[r.wba] = r.wbd;
        #1;
        check("stage empty after transfer", 32'(id_to_ex_valid), 0);
    endtask

    initial begin
        if_to_id_valid = 0;
        if_inst = 0;
        if_pc = 0;
        ex_allowin = 1;
        ex_fwd_we = 0;
        ex_fwd_waddr = 0;
        ex_fwd_wdata = 0;
        ex_fwd_is_load = 0;
        mem_fwd_we = 0;
        mem_fwd_waddr = 0;
        mem_fwd_wdata = 0;
        wb_rf_we = 0;
        wb_rf_waddr = 0;
        wb_rf_wdata = 0;
        passed = 0;
        failed = 0;
        void'($urandom(32'ha958_9cd8));
        build_table();
        table_ready = 1;
        wait (resetn);
        @(negedge clk);
        row_errs = 0;
        check("id_allowin after reset", 32'(id_allowin), 1);
        check("id_to_ex_valid after reset", 32'(id_to_ex_valid), 0);
        check("br_taken after reset", 32'(br_taken), 0);
        check("ex_rf_we after reset", 32'(ex_rf_we), 0);
        check("ex_mem_we after reset", 32'(ex_mem_we), 0);
        check("ex_res_from_mem after reset", 32'(ex_res_from_mem), 0);
        report_test("reset");
        preload();
        foreach (rows[i]) begin
            row_errs = 0;
            run_row(rows[i]);
            report_test($sformatf("%0d %s", i, rows[i].name));
        end
        $display("tests %0d, passed %0d, failed %0d", passed + failed, passed, failed);
        if (failed == 0)
            $display("Everything OK");
        else
            $display("Something failed");
        $finish;
    end

    // ten cycles per row and per preload write
    initial begin
        wait (table_ready);
        #(time'(rows.size() + preload_writes) * 40);
        $display("timeout: the run did not finish in time");
        $display("Something failed");
        $finish;
    end

endmodule

`default_nettype wire

/* test/tb_clock.sv */
`timescale 1ns/10ps
`default_nettype none

module tb_clock (
    output logic clk,
    output logic resetn
);

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;  // 4 ns period
    end

    initial begin
        resetn = 1'b0;
        repeat (5) @(posedge clk);
        @(negedge clk);
        resetn = 1'b1;
    end

endmodule

`default_nettype wire
